//--- verilog/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define CACHE_DATA_W      32
`define CACHE_ADDR_W      12
`define CACHE_INDEX_W     4   // 16 lines of one word each.
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W)
`define CACHE_WTB_DEPTH   4   // Also the number of credits held after reset.
`define CACHE_REG_ADDR_W  4

// **************************************************
// Control register map
// **************************************************
`define CACHE_RW_HIT_ADDR      4'd0
`define CACHE_RW_MISS_ADDR     4'd1
`define CACHE_READ_HIT_ADDR    4'd2
`define CACHE_READ_MISS_ADDR   4'd3
`define CACHE_WRITE_HIT_ADDR   4'd4
`define CACHE_WRITE_MISS_ADDR  4'd5
`define CACHE_RST_CNTRS_ADDR   4'd6
`define CACHE_INVALIDATE_ADDR  4'd7
`define CACHE_WTB_EMPTY_ADDR   4'd8
`define CACHE_WTB_FULL_ADDR    4'd9
`define CACHE_VERSION_ADDR     4'd10

`define CACHE_VERSION          32'h0000_0100

`endif

//--- verilog/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

   // One pending write-through on its way to memory.
   typedef struct packed {
      logic [`CACHE_ADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0] data;
   } wtb_entry_t;

   // Result of one completed CPU access, as reported to the counters.
   typedef enum logic [2:0] {
      ACC_NONE,
      ACC_READ_HIT,
      ACC_READ_MISS,
      ACC_WRITE_HIT,
      ACC_WRITE_MISS
   } access_kind_t;

endpackage

//--- verilog/cache_tag_lookup.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_tag_lookup (
   input  logic                      clk_i,
   input  logic                      reset,
   input  logic                      req_valid,
   input  logic                      req_we,
   input  logic [`CACHE_ADDR_W-1:0]  req_addr,
   input  logic [`CACHE_DATA_W-1:0]  req_wdata,
   output logic                      req_ready,
   output logic                      resp_valid,
   output logic [`CACHE_DATA_W-1:0]  resp_rdata,
   output logic                      mem_rreq,
   output logic [`CACHE_ADDR_W-1:0]  mem_raddr,
   input  logic                      mem_rvalid,
   input  logic [`CACHE_DATA_W-1:0]  mem_rdata,
   output logic                      wtb_push,
   output cache_pkg::wtb_entry_t     wtb_entry,
   input  logic                      wtb_credit,
   input  logic                      wtb_empty,
   input  logic                      invalidate,
   output cache_pkg::access_kind_t   access_kind
);
   import cache_pkg::*;

   localparam int LINES    = 1 << `CACHE_INDEX_W;
   localparam int CREDIT_W = $clog2(`CACHE_WTB_DEPTH + 1);

   typedef enum logic [1:0] {S_IDLE, S_DRAIN, S_FILL, S_RESP} state_t;

   state_t                    state_q;
   logic [LINES-1:0]          valid_q;
   logic [`CACHE_TAG_W-1:0]   tag_q [LINES];
   logic [`CACHE_DATA_W-1:0]  data_q [LINES];
   logic [CREDIT_W-1:0]       credits_q;
   logic [`CACHE_ADDR_W-1:0]  addr_q;
   logic [`CACHE_DATA_W-1:0]  wdata_q;
   logic                      we_q;
   access_kind_t              kind_q;
   logic [`CACHE_INDEX_W-1:0] req_index;
   logic [`CACHE_INDEX_W-1:0] fill_index;
   logic [`CACHE_TAG_W-1:0]   req_tag;
   logic                      hit;
   logic                      accept;
   logic                      fill_done;

   assign req_index  = req_addr[`CACHE_INDEX_W-1:0];
   assign req_tag    = req_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
   assign fill_index = addr_q[`CACHE_INDEX_W-1:0];
   assign hit        = valid_q[req_index] && (tag_q[req_index] == req_tag);

   // Writes need a free buffer entry, reads do not.
   assign req_ready = (state_q == S_IDLE) && (!req_we || (credits_q != '0));
   assign accept    = req_valid && req_ready;
   assign fill_done = (state_q == S_FILL) && mem_rvalid;

   assign resp_valid  = (state_q == S_RESP);
   assign mem_rreq    = (state_q == S_FILL);
   assign mem_raddr   = addr_q;
   assign wtb_push    = resp_valid && we_q;  // Push lands on the response cycle.
   assign wtb_entry   = '{addr: addr_q, data: wdata_q};
   assign access_kind = resp_valid ? kind_q : ACC_NONE;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE:  if (accept) state_q <= (req_we || hit) ? S_RESP : S_DRAIN;
            S_DRAIN: if (wtb_empty) state_q <= S_FILL;  // No stale data under a pending write.
            S_FILL:  if (mem_rvalid) state_q <= S_RESP;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         valid_q   <= '0;
         credits_q <= CREDIT_W'(`CACHE_WTB_DEPTH);
      end else begin
         credits_q <= credits_q + CREDIT_W'(wtb_credit) - CREDIT_W'(wtb_push);
         if (invalidate) valid_q <= '0;
         else if (fill_done) valid_q[fill_index] <= 1'b1;
      end
   end

   // **************************************************
   // Request capture and line storage
   // **************************************************
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
         we_q    <= req_we;
         if (req_we) kind_q <= hit ? ACC_WRITE_HIT : ACC_WRITE_MISS;
         else kind_q <= hit ? ACC_READ_HIT : ACC_READ_MISS;
         if (hit && !req_we) resp_rdata <= data_q[req_index];
         if (hit && req_we) data_q[req_index] <= req_wdata;  // Write misses do not allocate.
      end
      if (fill_done) begin
         tag_q[fill_index]  <= addr_q[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
         data_q[fill_index] <= mem_rdata;
         resp_rdata         <= mem_rdata;
      end
   end

endmodule

//--- verilog/cache_wtbuf.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_wtbuf (
   input  logic                   clk_i,
   input  logic                   reset,
   input  logic                   wtb_push,
   input  cache_pkg::wtb_entry_t  wtb_entry,
   input  logic                   wtb_pop,
   output cache_pkg::wtb_entry_t  wtb_head,
   output logic                   wtb_empty,
   output logic                   wtb_full,
   output logic                   wtb_credit
);
   import cache_pkg::*;

   localparam int PTR_W = $clog2(`CACHE_WTB_DEPTH);
   localparam int CNT_W = $clog2(`CACHE_WTB_DEPTH + 1);

   wtb_entry_t       fifo_q [`CACHE_WTB_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`CACHE_WTB_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign wtb_head  = fifo_q[rd_ptr_q];
   assign wtb_empty = (count_q == '0);
   assign wtb_full  = (count_q == CNT_W'(`CACHE_WTB_DEPTH));

   always_ff @(posedge clk_i) begin
      if (wtb_push) fifo_q[wr_ptr_q] <= wtb_entry;
   end

   // Pushes are bounded by the lookup's credits, so no overflow check here.
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         wtb_credit <= 1'b0;
      end else begin
         if (wtb_push) wr_ptr_q <= next_ptr(wr_ptr_q);
         if (wtb_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
         count_q    <= count_q + CNT_W'(wtb_push) - CNT_W'(wtb_pop);
         wtb_credit <= wtb_pop;  // One credit back per entry taken.
      end
   end

endmodule

//--- verilog/cache_mem_writer.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_mem_writer (
   input  logic                      clk_i,
   input  logic                      reset,
   input  logic                      wtb_empty,
   input  cache_pkg::wtb_entry_t     wtb_head,
   output logic                      wtb_pop,
   output logic                      mem_wvalid,
   output logic [`CACHE_ADDR_W-1:0]  mem_waddr,
   output logic [`CACHE_DATA_W-1:0]  mem_wdata,
   input  logic                      mem_wready
);
   import cache_pkg::*;

   wtb_entry_t entry_q;
   logic       busy_q;

   // Only one entry is held at a time.
   assign wtb_pop = !busy_q && !wtb_empty;

   assign mem_wvalid = busy_q;
   assign mem_waddr  = entry_q.addr;
   assign mem_wdata  = entry_q.data;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         busy_q <= 1'b0;
      end else if (wtb_pop) begin
         busy_q <= 1'b1;
      end else if (mem_wvalid && mem_wready) begin
         busy_q <= 1'b0;  // Released the cycle after the transfer.
      end
   end

   // The entry stays put while memory stalls.
   always_ff @(posedge clk_i) begin
      if (wtb_pop) entry_q <= wtb_head;
   end

endmodule

//--- verilog/cache_control.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_control (
   input  logic                         clk_i,
   input  logic                         reset,
   input  logic                         ctrl_valid,
   input  logic [`CACHE_REG_ADDR_W-1:0] ctrl_addr,
   output logic [`CACHE_DATA_W-1:0]     ctrl_rdata,
   output logic                         ctrl_ready,
   input  cache_pkg::access_kind_t      access_kind,
   input  logic                         wtb_full,
   input  logic                         wtb_empty,
   output logic                         invalidate
);
   import cache_pkg::*;

   logic [`CACHE_DATA_W-1:0] read_hit_cnt_q;
   logic [`CACHE_DATA_W-1:0] read_miss_cnt_q;
   logic [`CACHE_DATA_W-1:0] write_hit_cnt_q;
   logic [`CACHE_DATA_W-1:0] write_miss_cnt_q;
   logic [`CACHE_DATA_W-1:0] hit_total;
   logic [`CACHE_DATA_W-1:0] miss_total;
   logic                     clear_cnt;

   assign hit_total  = read_hit_cnt_q + write_hit_cnt_q;
   assign miss_total = read_miss_cnt_q + write_miss_cnt_q;

   // Both commands act on the edge that samples the request.
   assign clear_cnt  = ctrl_valid && (ctrl_addr == `CACHE_RST_CNTRS_ADDR);
   assign invalidate = ctrl_valid && (ctrl_addr == `CACHE_INVALIDATE_ADDR);

   // **************************************************
   // Performance counters
   // **************************************************
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         read_hit_cnt_q   <= '0;
         read_miss_cnt_q  <= '0;
         write_hit_cnt_q  <= '0;
         write_miss_cnt_q <= '0;
      end else if (clear_cnt) begin
         read_hit_cnt_q   <= '0;
         read_miss_cnt_q  <= '0;
         write_hit_cnt_q  <= '0;
         write_miss_cnt_q <= '0;
      end else begin
         case (access_kind)
            ACC_READ_HIT:   read_hit_cnt_q   <= read_hit_cnt_q + 1'b1;
            ACC_READ_MISS:  read_miss_cnt_q  <= read_miss_cnt_q + 1'b1;
            ACC_WRITE_HIT:  write_hit_cnt_q  <= write_hit_cnt_q + 1'b1;
            ACC_WRITE_MISS: write_miss_cnt_q <= write_miss_cnt_q + 1'b1;
            default: ;
         endcase
      end
   end

   // **************************************************
   // Register read port
   // **************************************************
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         ctrl_ready <= 1'b0;
      end else begin
         ctrl_ready <= ctrl_valid;
      end
   end

   always_ff @(posedge clk_i) begin
      ctrl_rdata <= '0;  // Commands and unknown addresses read zero.
      if (ctrl_valid) begin
         case (ctrl_addr)
            `CACHE_RW_HIT_ADDR:     ctrl_rdata <= hit_total;
            `CACHE_RW_MISS_ADDR:    ctrl_rdata <= miss_total;
            `CACHE_READ_HIT_ADDR:   ctrl_rdata <= read_hit_cnt_q;
            `CACHE_READ_MISS_ADDR:  ctrl_rdata <= read_miss_cnt_q;
            `CACHE_WRITE_HIT_ADDR:  ctrl_rdata <= write_hit_cnt_q;
            `CACHE_WRITE_MISS_ADDR: ctrl_rdata <= write_miss_cnt_q;
            `CACHE_WTB_EMPTY_ADDR:  ctrl_rdata <= {{(`CACHE_DATA_W-1){1'b0}}, wtb_empty};
            `CACHE_WTB_FULL_ADDR:   ctrl_rdata <= {{(`CACHE_DATA_W-1){1'b0}}, wtb_full};
            `CACHE_VERSION_ADDR:    ctrl_rdata <= `CACHE_VERSION;
            default: ;
         endcase
      end
   end

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_top (
   input  logic                         clk_i,
   input  logic                         reset,
   input  logic                         req_valid,
   input  logic                         req_we,
   input  logic [`CACHE_ADDR_W-1:0]     req_addr,
   input  logic [`CACHE_DATA_W-1:0]     req_wdata,
   output logic                         req_ready,
   output logic                         resp_valid,
   output logic [`CACHE_DATA_W-1:0]     resp_rdata,
   output logic                         mem_rreq,
   output logic [`CACHE_ADDR_W-1:0]     mem_raddr,
   input  logic                         mem_rvalid,
   input  logic [`CACHE_DATA_W-1:0]     mem_rdata,
   output logic                         mem_wvalid,
   output logic [`CACHE_ADDR_W-1:0]     mem_waddr,
   output logic [`CACHE_DATA_W-1:0]     mem_wdata,
   input  logic                         mem_wready,
   input  logic                         ctrl_valid,
   input  logic [`CACHE_REG_ADDR_W-1:0] ctrl_addr,
   output logic [`CACHE_DATA_W-1:0]     ctrl_rdata,
   output logic                         ctrl_ready
);
   import cache_pkg::*;

   wtb_entry_t   wtb_entry;
   wtb_entry_t   wtb_head;
   access_kind_t access_kind;
   logic         wtb_push;
   logic         wtb_pop;
   logic         wtb_empty;
   logic         wtb_full;
   logic         wtb_credit;
   logic         invalidate;
   logic         wtb_drained;

   // A read miss waits until no write is left in the buffer or held by the writer.
   assign wtb_drained = wtb_empty && !mem_wvalid;

   cache_tag_lookup tag_lookup_i (
      .clk_i       (clk_i),
      .reset       (reset),
      .req_valid   (req_valid),
      .req_we      (req_we),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_rdata  (resp_rdata),
      .mem_rreq    (mem_rreq),
      .mem_raddr   (mem_raddr),
      .mem_rvalid  (mem_rvalid),
      .mem_rdata   (mem_rdata),
      .wtb_push    (wtb_push),
      .wtb_entry   (wtb_entry),
      .wtb_credit  (wtb_credit),
      .wtb_empty   (wtb_drained),
      .invalidate  (invalidate),
      .access_kind (access_kind)
   );

   // The write-through path runs from the lookup through the buffer to memory.
   cache_wtbuf wtbuf_i (
      .clk_i      (clk_i),
      .reset      (reset),
      .wtb_push   (wtb_push),
      .wtb_entry  (wtb_entry),
      .wtb_pop    (wtb_pop),
      .wtb_head   (wtb_head),
      .wtb_empty  (wtb_empty),
      .wtb_full   (wtb_full),
      .wtb_credit (wtb_credit)
   );

   cache_mem_writer mem_writer_i (
      .clk_i      (clk_i),
      .reset      (reset),
      .wtb_empty  (wtb_empty),
      .wtb_head   (wtb_head),
      .wtb_pop    (wtb_pop),
      .mem_wvalid (mem_wvalid),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata),
      .mem_wready (mem_wready)
   );

   cache_control control_i (
      .clk_i       (clk_i),
      .reset       (reset),
      .ctrl_valid  (ctrl_valid),
      .ctrl_addr   (ctrl_addr),
      .ctrl_rdata  (ctrl_rdata),
      .ctrl_ready  (ctrl_ready),
      .access_kind (access_kind),
      .wtb_full    (wtb_full),
      .wtb_empty   (wtb_empty),
      .invalidate  (invalidate)
   );

endmodule

//--- verif/cache_tb_clock.sv
`timescale 1ns/10ps

module cache_tb_clock (
   output logic clk_i,
   output logic reset
);

   localparam time HALF_PERIOD = 10ns;  // 20 ns clock.

   initial begin
      clk_i = 1'b0;
      forever #(HALF_PERIOD) clk_i = ~clk_i;
   end

   // Reset stays high over the first five rising edges.
   initial begin
      reset = 1'b1;
      repeat (5) @(posedge clk_i);
      reset <= 1'b0;
   end

endmodule

//--- verif/cache_tb.sv
`timescale 1ns/10ps

`include "cache_macros.svh"

module cache_tb;
   import cache_pkg::*;

   localparam int LINES          = 1 << `CACHE_INDEX_W;
   localparam int N_RANDOM       = 60;
   localparam int STALL_CYCLES   = 20;
   localparam int TOTAL_ACCESSES = 2 + 9 + (`CACHE_WTB_DEPTH + 2) + N_RANDOM + 2;
   localparam int MAX_CYCLES     = 40 * TOTAL_ACCESSES + 2000;

   logic                         clk_i;
   logic                         reset;
   logic                         req_valid;
   logic                         req_we;
   logic [`CACHE_ADDR_W-1:0]     req_addr;
   logic [`CACHE_DATA_W-1:0]     req_wdata;
   logic                         req_ready;
   logic                         resp_valid;
   logic [`CACHE_DATA_W-1:0]     resp_rdata;
   logic                         mem_rreq;
   logic [`CACHE_ADDR_W-1:0]     mem_raddr;
   logic                         mem_rvalid;
   logic [`CACHE_DATA_W-1:0]     mem_rdata;
   logic                         mem_wvalid;
   logic [`CACHE_ADDR_W-1:0]     mem_waddr;
   logic [`CACHE_DATA_W-1:0]     mem_wdata;
   logic                         mem_wready;
   logic                         ctrl_valid;
   logic [`CACHE_REG_ADDR_W-1:0] ctrl_addr;
   logic [`CACHE_DATA_W-1:0]     ctrl_rdata;
   logic                         ctrl_ready;

   integer                   seed = 91;
   logic [`CACHE_DATA_W-1:0] mem_model [1 << `CACHE_ADDR_W];
   logic [`CACHE_DATA_W-1:0] ref_data [1 << `CACHE_ADDR_W];  // Memory as the CPU should see it.
   logic                     ref_valid [LINES];
   logic [`CACHE_TAG_W-1:0]  ref_tag [LINES];
   wtb_entry_t               wr_expect [$];
   int exp_rd_hit;
   int exp_rd_miss;
   int exp_wr_hit;
   int exp_wr_miss;
   int errors;
   int checks;
   int tests_failed;
   int test_errors;
   int cycles;
   int pushes_cnt;
   int wr_done_cnt;
   int rd_done_cnt;
   int wtb_model_cnt;
   string test_name;
   logic                     hold_wready;
   logic                     acc_seen = 1'b0;
   logic                     resp_seen = 1'b0;
   logic [`CACHE_DATA_W-1:0] resp_data;

   cache_tb_clock clock_i (.clk_i(clk_i), .reset(reset));

   cache_top cache_top_i (
      .clk_i      (clk_i),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_we     (req_we),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp_rdata (resp_rdata),
      .mem_rreq   (mem_rreq),
      .mem_raddr  (mem_raddr),
      .mem_rvalid (mem_rvalid),
      .mem_rdata  (mem_rdata),
      .mem_wvalid (mem_wvalid),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata),
      .mem_wready (mem_wready),
      .ctrl_valid (ctrl_valid),
      .ctrl_addr  (ctrl_addr),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_ready (ctrl_ready)
   );

   // The buffer holds what was pushed, less what was written and the one the writer holds.
   assign wtb_model_cnt = pushes_cnt - wr_done_cnt - int'(mem_wvalid);

   function automatic logic [`CACHE_DATA_W-1:0] fill_word(input logic [`CACHE_ADDR_W-1:0] a);
      return {8'hc5, a, ~a};
   endfunction

   task automatic expect_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
      checks++;
      assert (actual === expected)
      else begin
         $display("** Error %s, %s: expected %h, actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   // **************************************************
   // Port assertions
   // **************************************************
   assert property (@(posedge clk_i) disable iff (reset) ctrl_ready == $past(ctrl_valid))
   else begin
      $display("Control ready did not follow the request by exactly one cycle.");
      errors++;
   end

   assert property (@(posedge clk_i) disable iff (reset)
                    (req_valid && req_we && req_ready) |-> (wtb_model_cnt < `CACHE_WTB_DEPTH))
   else begin
      $display("A write was accepted while the write buffer was full.");
      errors++;
   end

   assert property (@(posedge clk_i) disable iff (reset)
                    (mem_wvalid && !mem_wready) |=>
                    (mem_wvalid && $stable(mem_waddr) && $stable(mem_wdata)))
   else begin
      $display("The memory write request changed before memory accepted it.");
      errors++;
   end

   // Handshakes seen at the rising edge, read by the stimulus on the next falling edge.
   always @(posedge clk_i) begin
      acc_seen  <= req_valid && req_ready;
      resp_seen <= resp_valid;
      resp_data <= resp_rdata;
      if (resp_valid && req_we) pushes_cnt <= pushes_cnt + 1;
      if (mem_rreq && mem_rvalid) rd_done_cnt <= rd_done_cnt + 1;
   end

   always @(posedge clk_i) begin
      wtb_entry_t exp_w;
      if (!reset && mem_wvalid && mem_wready) begin
         assert (wr_expect.size() != 0)
         else begin
            $display("Memory write to %h with no write pending.", mem_waddr);
            errors++;
         end
         if (wr_expect.size() != 0) begin
            exp_w = wr_expect.pop_front();
            expect_value("write address", 32'(exp_w.addr), 32'(mem_waddr));
            expect_value("write data", exp_w.data, mem_wdata);
         end
         mem_model[mem_waddr] = mem_wdata;
         wr_done_cnt <= wr_done_cnt + 1;
      end
   end

   // **************************************************
   // Memory model
   // **************************************************
   initial begin : mem_read_model
      int delay;
      mem_rvalid = 1'b0;
      mem_rdata  = '0;
      forever begin
         @(negedge clk_i);
         if (mem_rreq) begin
            delay = 1 + ($random(seed) & 3);  // One to four cycles.
            repeat (delay - 1) @(negedge clk_i);
            expect_value("read address", 32'(req_addr), 32'(mem_raddr));
            mem_rdata  = mem_model[mem_raddr];
            mem_rvalid = 1'b1;
            @(negedge clk_i);
            mem_rvalid = 1'b0;
         end
      end
   end

   always @(negedge clk_i) begin
      if (hold_wready) mem_wready = 1'b0;
      else mem_wready = 1'($random(seed));
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, a handshake never completed.", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   // **************************************************
   // Stimulus tasks
   // **************************************************
   task automatic start_request(input logic we, input logic [`CACHE_ADDR_W-1:0] addr,
                                input logic [`CACHE_DATA_W-1:0] wdata);
      req_valid = 1'b1;
      req_we    = we;
      req_addr  = addr;
      req_wdata = wdata;
   endtask

   // Waits for acceptance and response, then checks against the reference model.
   task automatic finish_request();
      logic [`CACHE_INDEX_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0]   tag;
      logic                      hit;
      int                        rd_before;
      wtb_entry_t                w;
      idx       = req_addr[`CACHE_INDEX_W-1:0];
      tag       = req_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      hit       = ref_valid[idx] && (ref_tag[idx] == tag);
      rd_before = rd_done_cnt;
      do @(negedge clk_i); while (!acc_seen);
      req_valid = 1'b0;
      if (req_we) begin
         w.addr = req_addr;
         w.data = req_wdata;
         wr_expect.push_back(w);
         ref_data[req_addr] = req_wdata;
      end
      while (!resp_seen) @(negedge clk_i);
      if (req_we) begin
         if (hit) exp_wr_hit++;
         else exp_wr_miss++;  // No allocation on a write miss.
      end else begin
         expect_value("read data", ref_data[req_addr], resp_data);
         if (hit) begin
            exp_rd_hit++;
         end else begin
            exp_rd_miss++;
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
         end
      end
      expect_value("memory reads", (hit || req_we) ? 32'd0 : 32'd1, 32'(rd_done_cnt - rd_before));
   endtask

   task automatic cpu_access(input logic we, input logic [`CACHE_ADDR_W-1:0] addr,
                             input logic [`CACHE_DATA_W-1:0] wdata);
      start_request(we, addr, wdata);
      finish_request();
   endtask

   task automatic ctrl_access(input logic [`CACHE_REG_ADDR_W-1:0] addr,
                              output logic [`CACHE_DATA_W-1:0] data);
      ctrl_valid = 1'b1;
      ctrl_addr  = addr;
      @(negedge clk_i);
      ctrl_valid = 1'b0;
      data       = ctrl_rdata;
   endtask

   task automatic expect_reg(input string what, input logic [`CACHE_REG_ADDR_W-1:0] addr,
                             input logic [31:0] expected);
      logic [`CACHE_DATA_W-1:0] data;
      ctrl_access(addr, data);
      expect_value(what, expected, data);
   endtask

   task automatic check_counters();
      expect_reg("read hits", `CACHE_READ_HIT_ADDR, exp_rd_hit);
      expect_reg("read misses", `CACHE_READ_MISS_ADDR, exp_rd_miss);
      expect_reg("write hits", `CACHE_WRITE_HIT_ADDR, exp_wr_hit);
      expect_reg("write misses", `CACHE_WRITE_MISS_ADDR, exp_wr_miss);
      expect_reg("total hits", `CACHE_RW_HIT_ADDR, exp_rd_hit + exp_wr_hit);
      expect_reg("total misses", `CACHE_RW_MISS_ADDR, exp_rd_miss + exp_wr_miss);
   endtask

   task automatic clear_counters();
      logic [`CACHE_DATA_W-1:0] unused;
      ctrl_access(`CACHE_RST_CNTRS_ADDR, unused);
      exp_rd_hit  = 0;
      exp_rd_miss = 0;
      exp_wr_hit  = 0;
      exp_wr_miss = 0;
   endtask

   task automatic invalidate_cache();
      logic [`CACHE_DATA_W-1:0] unused;
      ctrl_access(`CACHE_INVALIDATE_ADDR, unused);
      for (int i = 0; i < LINES; i++) ref_valid[i] = 1'b0;
   endtask

   task automatic wait_drain();
      while (wr_expect.size() != 0) @(negedge clk_i);
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = errors;
   endtask

   task automatic end_test();
      if (errors == test_errors) begin
         $display("Test %s: done, no errors", test_name);
      end else begin
         $display("Test %s: done, %0d errors", test_name, errors - test_errors);
         tests_failed++;
      end
   endtask

   // **************************************************
   // Test sequence
   // **************************************************
   initial begin : stimulus
      logic [31:0] r;
      req_valid   = 1'b0;
      req_we      = 1'b0;
      req_addr    = '0;
      req_wdata   = '0;
      mem_wready  = 1'b0;
      ctrl_valid  = 1'b0;
      ctrl_addr   = '0;
      hold_wready = 1'b0;
      for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
         mem_model[a] = fill_word(`CACHE_ADDR_W'(a));
         ref_data[a]  = mem_model[a];
      end
      for (int i = 0; i < LINES; i++) ref_valid[i] = 1'b0;
      @(negedge reset);
      @(negedge clk_i);

      begin_test("read miss then hit");
      cpu_access(1'b0, 12'h123, '0);
      cpu_access(1'b0, 12'h123, '0);
      end_test();

      begin_test("write-through");
      cpu_access(1'b1, 12'h123, 32'($random(seed)));
      cpu_access(1'b1, 12'h456, 32'($random(seed)));
      cpu_access(1'b1, 12'h123, 32'($random(seed)));
      cpu_access(1'b0, 12'h456, '0);  // Miss behind pending writes.
      cpu_access(1'b0, 12'h123, '0);
      cpu_access(1'b1, 12'h456, 32'($random(seed)));
      cpu_access(1'b1, 12'h789, 32'($random(seed)));
      cpu_access(1'b0, 12'h789, '0);
      cpu_access(1'b0, 12'h456, '0);
      wait_drain();
      end_test();

      begin_test("back-pressure");
      wait_drain();
      hold_wready = 1'b1;
      @(negedge clk_i);
      // The writer keeps one entry, so one write more than the buffer depth gets in.
      for (int k = 0; k <= `CACHE_WTB_DEPTH; k++) begin
         cpu_access(1'b1, 12'h300 + 12'(k), 32'($random(seed)));
      end
      start_request(1'b1, 12'h3f0, 32'($random(seed)));
      repeat (STALL_CYCLES) begin
         @(negedge clk_i);
         assert (!acc_seen)
         else begin
            $display("A write went through while the buffer was full.");
            errors++;
         end
      end
      expect_reg("full flag", `CACHE_WTB_FULL_ADDR, 32'd1);
      expect_reg("empty flag", `CACHE_WTB_EMPTY_ADDR, 32'd0);
      hold_wready = 1'b0;
      finish_request();
      wait_drain();
      expect_reg("empty flag", `CACHE_WTB_EMPTY_ADDR, 32'd1);
      expect_reg("full flag", `CACHE_WTB_FULL_ADDR, 32'd0);
      end_test();

      begin_test("counters");
      for (int i = 0; i < N_RANDOM; i++) begin
         r = $random(seed);
         cpu_access(r[0], {6'h0, r[9:4]}, 32'($random(seed)));
      end
      check_counters();
      clear_counters();
      check_counters();
      end_test();

      begin_test("invalidate and version");
      cpu_access(1'b0, 12'h123, '0);
      invalidate_cache();
      cpu_access(1'b0, 12'h123, '0);  // Must go to memory again.
      expect_reg("version", `CACHE_VERSION_ADDR, `CACHE_VERSION);
      expect_reg("unused register", 4'd11, 32'd0);
      end_test();

      wait_drain();
      $display("Tests run: 5, tests failed: %0d, checks: %0d, errors: %0d",
               tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- compile.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_tag_lookup.sv
verilog/cache_wtbuf.sv
verilog/cache_mem_writer.sv
verilog/cache_control.sv
verilog/cache_top.sv
verif/cache_tb_clock.sv
verif/cache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= cache_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/cache_macros.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
